/* verification/decompress_input.txt */
# name  d  num_poly  src_base  dest_base  fill_hex (0 = random)  writes  zeroize_cycle (0 = none)
# Bases are decimal word addresses, writes is the expected number of 48-bit destination writes
d1_p1        1  1     0    0  0                  64   0
d5_p2        5  2    16  100  0                 128   0
d11_p3      11  3    60  300  0                 192   0
d12_p4      12  4   200  500  0                 256   0
d1_p4        1  4   500   20  0                 256   0
d1_wrap      1  2  1020  200  0                 128   0
d5_fill      5  1   900  700  0123456789abcdef   64   0
d12_ones    12  1     0  800  ffffffffffffffff   64   0
d11_abort   11  2   100    0  0                   0  30
d12_after   12  1   100    0  0                  64   0
d11_p4      11  4   400  600  0                 256   0

/* list.f */
hdl/decompress_pkg.sv
hdl/decompress_job_if.sv
hdl/decompress_fsm.sv
hdl/decompress_addr_ctr.sv
hdl/decompress_gearbox.sv
hdl/decompress_lane.sv
hdl/decompress_top.sv
verification/decompress_tb.sv

/* verification/decompress_tb.sv */
// Self-checking testbench for the decompression engine that runs the jobs of the input vector file

`timescale 1ns/1ps

module decompress_tb
    import decompress_pkg::*;
();

    localparam int ADDR_W        = 10;
    localparam int MEM_DEPTH     = 1 << ADDR_W;
    localparam int DONE_TIMEOUT  = 5000;
    localparam int SETTLE_CYCLES = 4;
    localparam int ZEROIZE_WATCH = 8;

    logic                  clk;
    logic                  reset_n;
    logic                  zeroize_i;
    logic                  enable_i;
    decompress_mode_t      mode_i;
    logic [NUM_POLY_W-1:0] num_poly_i;
    logic [ADDR_W-1:0]     src_base_i;
    logic [ADDR_W-1:0]     dest_base_i;
    logic [RD_DATA_W-1:0]  rd_data_i;
    logic                  rd_en_o;
    logic [ADDR_W-1:0]     rd_addr_o;
    logic                  wr_en_o;
    logic [ADDR_W-1:0]     wr_addr_o;
    logic [GEAR_OUT_W-1:0] wr_data_o;
    logic                  done_o;

    logic [RD_DATA_W-1:0]  src_mem [0:MEM_DEPTH-1];

    // Activity seen on the memory ports during the current job
    logic [ADDR_W-1:0]     rd_log [$];
    logic [ADDR_W-1:0]     wr_addr_log [$];
    logic [GEAR_OUT_W-1:0] wr_data_log [$];
    int                    done_cnt;
    int                    reads_at_done;
    int                    writes_at_done;

    // Current line of the vector file
    string                 cur_test;
    int                    job_d;
    int                    job_poly;
    int                    job_src;
    int                    job_dest;
    logic [63:0]           job_fill;
    int                    job_writes;
    int                    job_zeroize;
    int                    jobs_run;

    decompress_top #(.ADDR_W(ADDR_W)) uut (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize_i  (zeroize_i),
        .enable_i   (enable_i),
        .mode_i     (mode_i),
        .num_poly_i (num_poly_i),
        .src_base_i (src_base_i),
        .dest_base_i(dest_base_i),
        .rd_en_o    (rd_en_o),
        .rd_addr_o  (rd_addr_o),
        .rd_data_i  (rd_data_i),
        .wr_en_o    (wr_en_o),
        .wr_addr_o  (wr_addr_o),
        .wr_data_o  (wr_data_o),
        .done_o     (done_o)
    );

    always #20 clk = ~clk;

    // Source memory with one cycle of read latency whose output holds between reads
    always @(posedge clk) begin
        if (rd_en_o) begin
            rd_data_i <= src_mem[rd_addr_o];
        end
    end

    always @(posedge clk) begin
        if (reset_n) begin
            if (rd_en_o) begin
                rd_log.push_back(rd_addr_o);
            end
            if (wr_en_o) begin
                wr_addr_log.push_back(wr_addr_o);
                wr_data_log.push_back(wr_data_o);
            end
            if (done_o) begin
                done_cnt++;
                reads_at_done  = rd_log.size();
                writes_at_done = wr_addr_log.size();
            end
        end
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH test %s, %s: expected %0h, actual %0h",
                     cur_test, what, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic stop_with_error(input string msg);
        $display("ERROR: %s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "Run stopped");
    endtask

    function automatic decompress_mode_t mode_for_width(input int d);
        case (d)
            1:       return DECOMP_D1;
            5:       return DECOMP_D5;
            11:      return DECOMP_D11;
            default: return DECOMP_D12;
        endcase
    endfunction

    // Expected coefficient j of the packed stream that starts at word src
    function automatic logic [11:0] ref_coeff(input int d, input int src, input int j);
        logic [11:0] x;
        int          pos;
        int          rounded;
        x = '0;
        for (int b = 0; b < d; b++) begin
            pos  = j * d + b;
            x[b] = src_mem[(src + pos / 64) % MEM_DEPTH][pos % 64];
        end
        if (d == 12) begin
            return (x >= MLKEM_Q) ? x - 12'(MLKEM_Q) : x;
        end
        rounded = (int'(x) * MLKEM_Q + (1 << (d - 1))) >> d;
        return rounded[11:0];
    endfunction

    task automatic load_source(input int reads);
        int a;
        int r;
        for (int k = 0; k < reads; k++) begin
            a = (job_src + k) % MEM_DEPTH;
            r = a % 61;
            if (job_fill == 64'd0) begin
                src_mem[a] = {$urandom, $urandom};
            end else begin
                // Rotation varies a fill per word and leaves all ones unchanged
                src_mem[a] = (job_fill << r) | (job_fill >> (64 - r));
            end
        end
    endtask

    task automatic run_job();
        int               reads;
        int               writes;
        int               cyc;
        bit               seen_done;
        logic [47:0]      expected;
        if (job_d != 1 && job_d != 5 && job_d != 11 && job_d != 12) begin
            stop_with_error($sformatf("test %s has an unknown coefficient width", cur_test));
        end
        if (job_poly < 1 || job_poly > 4) begin
            stop_with_error($sformatf("test %s has an illegal polynomial count", cur_test));
        end
        reads  = job_poly * 4 * job_d;
        writes = job_poly * (MLKEM_N / COEFF_PER_CLK);
        load_source(reads);
        rd_log.delete();
        wr_addr_log.delete();
        wr_data_log.delete();
        done_cnt       = 0;
        reads_at_done  = 0;
        writes_at_done = 0;

        @(posedge clk);
        enable_i    <= 1'b1;
        mode_i      <= mode_for_width(job_d);
        num_poly_i  <= NUM_POLY_W'(job_poly);
        src_base_i  <= ADDR_W'(job_src);
        dest_base_i <= ADDR_W'(job_dest);
        @(posedge clk);
        enable_i <= 1'b0;

        if (job_zeroize > 0) begin
            repeat (job_zeroize - 1) @(posedge clk);
            zeroize_i <= 1'b1;
            @(posedge clk);
            zeroize_i <= 1'b0;
            // Engine must stay silent once the abort has taken effect
            repeat (ZEROIZE_WATCH) begin
                @(posedge clk);
                check_value("rd_en_o after zeroize", 0, rd_en_o);
                check_value("wr_en_o after zeroize", 0, wr_en_o);
                check_value("done_o after zeroize", 0, done_o);
            end
            check_value("done pulses after zeroize", 0, done_cnt);
        end else begin
            cyc       = 0;
            seen_done = 1'b0;
            while (!seen_done && cyc < DONE_TIMEOUT) begin
                @(posedge clk);
                cyc++;
                if (done_o) begin
                    seen_done = 1'b1;
                end
                // Stray strobe with other settings while the job runs
                if (cyc == 3) begin
                    enable_i    <= 1'b1;
                    mode_i      <= DECOMP_D1;
                    num_poly_i  <= NUM_POLY_W'(1);
                    src_base_i  <= ADDR_W'(job_src + 512);
                    dest_base_i <= ADDR_W'(job_dest + 512);
                end else begin
                    enable_i <= 1'b0;
                end
            end
            if (!seen_done) begin
                stop_with_error($sformatf("timeout waiting for done_o in test %s", cur_test));
            end
            repeat (SETTLE_CYCLES) @(posedge clk);
            check_value("done pulses", 1, done_cnt);
            check_value("write count from file", job_writes, wr_addr_log.size());
            check_value("write count", writes, wr_addr_log.size());
            check_value("writes after done", writes_at_done, wr_addr_log.size());
            check_value("read count", reads, rd_log.size());
            check_value("reads after done", reads_at_done, rd_log.size());
            for (int k = 0; k < rd_log.size(); k++) begin
                check_value("read address", (job_src + k) % MEM_DEPTH, rd_log[k]);
            end
        end

        // Aborted jobs still have to get their early writes right
        for (int w = 0; w < wr_addr_log.size(); w++) begin
            expected = {ref_coeff(job_d, job_src, 4 * w + 3),
                        ref_coeff(job_d, job_src, 4 * w + 2),
                        ref_coeff(job_d, job_src, 4 * w + 1),
                        ref_coeff(job_d, job_src, 4 * w)};
            check_value("write address", (job_dest + w) % MEM_DEPTH, wr_addr_log[w]);
            check_value("write data", expected, wr_data_log[w]);
            if (job_d == 12 && job_fill == '1) begin
                for (int l = 0; l < COEFF_PER_CLK; l++) begin
                    check_value("lane reduced by q", 4095 - MLKEM_Q,
                                wr_data_log[w][l*Q_WIDTH +: Q_WIDTH]);
                end
            end
        end
        jobs_run++;
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        clk         = 1'b0;
        reset_n     = 1'b0;
        zeroize_i   = 1'b0;
        enable_i    = 1'b0;
        mode_i      = DECOMP_D1;
        num_poly_i  = '0;
        src_base_i  = '0;
        dest_base_i = '0;
        rd_data_i   = '0;
        jobs_run    = 0;
        cur_test    = "none";
        void'($urandom(39));

        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        fd = $fopen("verification/decompress_input.txt", "r");
        if (fd == 0) begin
            stop_with_error("cannot open the vector file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Skip blank lines and column notes
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %d %d %h %d %d", cur_test, job_d, job_poly,
                        job_src, job_dest, job_fill, job_writes, job_zeroize);
            if (n != 8) begin
                stop_with_error($sformatf("malformed line in vector file: %s", line));
            end
            run_job();
        end
        $fclose(fd);

        if (jobs_run == 0) begin
            stop_with_error("the vector file holds no jobs");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

/* hdl/decompress_top.sv */
// Top level of the ML-KEM decompression engine with plain memory and control ports

`timescale 1ns/1ps

module decompress_top
    import decompress_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,

    input  logic                  enable_i,
    input  decompress_mode_t      mode_i,
    input  logic [NUM_POLY_W-1:0] num_poly_i,
    input  logic [ADDR_W-1:0]     src_base_i,
    input  logic [ADDR_W-1:0]     dest_base_i,

    // Source memory, one cycle read latency
    output logic                  rd_en_o,
    output logic [ADDR_W-1:0]     rd_addr_o,
    input  logic [RD_DATA_W-1:0]  rd_data_i,

    // Destination memory, lane 0 in the low bits
    output logic                  wr_en_o,
    output logic [ADDR_W-1:0]     wr_addr_o,
    output logic [GEAR_OUT_W-1:0] wr_data_o,

    output logic                  done_o
);

    logic                  gear_hold;
    logic                  gear_valid;
    logic [GEAR_OUT_W-1:0] gear_data;
    logic                  rd_valid;
    logic                  write_done;

    decompress_job_if #(.ADDR_W(ADDR_W)) job_if ();

    decompress_fsm #(.ADDR_W(ADDR_W)) fsm_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .enable_i    (enable_i),
        .mode_i      (mode_i),
        .num_poly_i  (num_poly_i),
        .src_base_i  (src_base_i),
        .dest_base_i (dest_base_i),
        .write_done_i(write_done),
        .job         (job_if.fsm_mp),
        .done_o      (done_o)
    );

    decompress_addr_ctr #(.ADDR_W(ADDR_W)) addr_ctr_inst (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize_i   (zeroize_i),
        .hold_i      (gear_hold),
        .wr_en_i     (gear_valid),
        .job         (job_if.user_mp),
        .rd_en_o     (rd_en_o),
        .rd_addr_o   (rd_addr_o),
        .rd_valid_o  (rd_valid),
        .wr_addr_o   (wr_addr_o),
        .write_done_o(write_done)
    );

    decompress_gearbox gearbox_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize_i(zeroize_i),
        .valid_i  (rd_valid),
        .data_i   (rd_data_i),
        .job      (job_if.user_mp),
        .hold_o   (gear_hold),
        .valid_o  (gear_valid),
        .data_o   (gear_data)
    );

    // Every gearbox group becomes one write
    assign wr_en_o = gear_valid;

    for (genvar i = 0; i < COEFF_PER_CLK; i++) begin : g_lane
        decompress_lane #(.LANE(i)) lane_inst (
            .data_i (gear_data),
            .job    (job_if.user_mp),
            .coeff_o(wr_data_o[i*Q_WIDTH +: Q_WIDTH])
        );
    end

endmodule

/* hdl/decompress_lane.sv */
// One decompression lane that picks its d-bit field and maps it onto 0 to q-1

`timescale 1ns/1ps

module decompress_lane
    import decompress_pkg::*;
#(
    parameter int LANE = 0
) (
    input  logic [GEAR_OUT_W-1:0] data_i,
    decompress_job_if.user_mp     job,
    output logic [Q_WIDTH-1:0]    coeff_o
);

    logic [3:0]         d;
    logic [Q_WIDTH-1:0] x;
    logic [23:0]        prod;
    logic [Q_WIDTH-1:0] rounded;
    logic [Q_WIDTH-1:0] reduced;

    assign d = decomp_d_width(job.mode);

    // Field LANE*d up to LANE*d+d-1
    always_comb begin
        unique case (job.mode)
            DECOMP_D1:  x = Q_WIDTH'(data_i[LANE*1 +: 1]);
            DECOMP_D5:  x = Q_WIDTH'(data_i[LANE*5 +: 5]);
            DECOMP_D11: x = Q_WIDTH'(data_i[LANE*11 +: 11]);
            DECOMP_D12: x = data_i[LANE*12 +: 12];
            default:    x = data_i[LANE*12 +: 12];
        endcase
    end

    // round(x*q / 2^d) by adding half an LSB before the shift
    assign prod    = 24'(x) * 24'(MLKEM_Q) + (24'd1 << (d - 4'd1));
    assign rounded = Q_WIDTH'(prod >> d);

    // Raw 12-bit values only need one subtraction to land below q
    assign reduced = (x >= Q_WIDTH'(MLKEM_Q)) ? x - Q_WIDTH'(MLKEM_Q) : x;

    assign coeff_o = (d == 4'd12) ? reduced : rounded;

endmodule

/* hdl/decompress_gearbox.sv */
// Multi-rate gearbox that buffers 64-bit source words and releases 4*d-bit coefficient groups

`timescale 1ns/1ps

module decompress_gearbox
    import decompress_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  valid_i,
    input  logic [RD_DATA_W-1:0]  data_i,
    decompress_job_if.user_mp     job,
    output logic                  hold_o,
    output logic                  valid_o,
    output logic [GEAR_OUT_W-1:0] data_o
);

    localparam int GEAR_BUF_W = 128;
    localparam int FILL_W     = $clog2(GEAR_BUF_W + 1);
    localparam int GROUP_W    = $clog2(GEAR_OUT_W + 1);

    logic [GEAR_BUF_W-1:0] shift_buf;
    logic [FILL_W-1:0]     fill_lvl;
    logic [GROUP_W-1:0]    group_w;
    logic [GROUP_W-1:0]    consume;
    logic [FILL_W-1:0]     fill_after;
    logic [GEAR_BUF_W-1:0] buf_shifted;
    logic [GEAR_BUF_W-1:0] buf_next;
    logic [FILL_W-1:0]     fill_next;
    logic                  accept;

    // Four coefficients of d bits each
    assign group_w = GROUP_W'(COEFF_PER_CLK * decomp_d_width(job.mode));

    // Less than one source word of room left
    assign hold_o  = fill_lvl > FILL_W'(GEAR_BUF_W - RD_DATA_W);
    assign accept  = valid_i & ~hold_o;
    assign valid_o = fill_lvl >= FILL_W'(group_w);
    assign consume = valid_o ? group_w : '0;

    // Oldest bits sit at the bottom, unused lane bits are zeroed
    // A 48-bit group shifts the mask fully out, leaving all ones
    assign data_o = shift_buf[GEAR_OUT_W-1:0] & ~({GEAR_OUT_W{1'b1}} << group_w);

    always_comb begin
        fill_after  = fill_lvl - FILL_W'(consume);
        buf_shifted = shift_buf >> consume;
        if (accept) begin
            // New word lands right above what is left
            buf_next  = buf_shifted | (GEAR_BUF_W'(data_i) << fill_after);
            fill_next = fill_after + FILL_W'(RD_DATA_W);
        end else begin
            buf_next  = buf_shifted;
            fill_next = fill_after;
        end
    end

    // Bits above the fill level are kept at zero so new words can be OR-ed in
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            shift_buf <= '0;
            fill_lvl  <= '0;
        end else if (zeroize_i) begin
            shift_buf <= '0;
            fill_lvl  <= '0;
        end else begin
            shift_buf <= buf_next;
            fill_lvl  <= fill_next;
        end
    end

    // Hold must throttle reads early enough to protect the buffer
    a_fill_in_range: assert property (@(posedge clk) disable iff (!reset_n)
        fill_lvl <= FILL_W'(GEAR_BUF_W));

endmodule

/* hdl/decompress_addr_ctr.sv */
// Source read and destination write address counters with their end-of-job flags

`timescale 1ns/1ps

module decompress_addr_ctr
    import decompress_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                zeroize_i,
    input  logic                hold_i,
    input  logic                wr_en_i,
    decompress_job_if.user_mp   job,
    output logic                rd_en_o,
    output logic [ADDR_W-1:0]   rd_addr_o,
    output logic                rd_valid_o,
    output logic [ADDR_W-1:0]   wr_addr_o,
    output logic                write_done_o
);

    // Up to 4 polys of 64 writes
    localparam int CNT_W = 9;

    logic [3:0]       d;
    logic [CNT_W-1:0] rd_cnt;
    logic [CNT_W-1:0] wr_cnt;
    logic [CNT_W-1:0] rd_limit;
    logic [CNT_W-1:0] wr_limit;
    logic             read_done;

    assign d = decomp_d_width(job.mode);

    // 4*d source words and 64 write groups per polynomial
    assign rd_limit = CNT_W'(job.num_poly) * CNT_W'((MLKEM_N / RD_DATA_W) * d);
    assign wr_limit = CNT_W'(job.num_poly) * CNT_W'(MLKEM_N / COEFF_PER_CLK);

    assign read_done = (rd_cnt == rd_limit);
    assign rd_en_o   = job.busy & ~read_done & ~hold_i;

    assign rd_addr_o = job.src_base + ADDR_W'(rd_cnt);
    assign wr_addr_o = job.dest_base + ADDR_W'(wr_cnt);

    // Flags the write that completes the job
    assign write_done_o = wr_en_i & (wr_cnt == wr_limit - 1'b1);

    // Offsets restart whenever no job is running
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else if (zeroize_i || !job.busy) begin
            rd_cnt <= '0;
            wr_cnt <= '0;
        end else begin
            if (rd_en_o) begin
                rd_cnt <= rd_cnt + 1'b1;
            end
            if (wr_en_i) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // Read data arrives a cycle later and stays pending while the gearbox is full
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_valid_o <= 1'b0;
        end else if (zeroize_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_o | (rd_valid_o & hold_i);
        end
    end

    // Gearbox drains exactly at the last write
    a_no_write_after_done: assert property (@(posedge clk) disable iff (!reset_n)
        write_done_o |=> !wr_en_i);

endmodule

/* hdl/decompress_fsm.sv */
// Control FSM that accepts a decompression job, holds its settings and pulses done at the end

`timescale 1ns/1ps

module decompress_fsm
    import decompress_pkg::*;
#(
    parameter int ADDR_W = 10
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  zeroize_i,
    input  logic                  enable_i,
    input  decompress_mode_t      mode_i,
    input  logic [NUM_POLY_W-1:0] num_poly_i,
    input  logic [ADDR_W-1:0]     src_base_i,
    input  logic [ADDR_W-1:0]     dest_base_i,
    input  logic                  write_done_i,
    decompress_job_if.fsm_mp      job,
    output logic                  done_o
);

    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } state_t;

    state_t                state;
    decompress_mode_t      mode_q;
    logic [NUM_POLY_W-1:0] num_poly_q;
    logic [ADDR_W-1:0]     src_base_q;
    logic [ADDR_W-1:0]     dest_base_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (zeroize_i) begin
            state <= IDLE;
        end else begin
            unique case (state)
                IDLE: begin
                    if (enable_i) begin
                        state <= RUN;
                    end
                end
                RUN: begin
                    if (write_done_i) begin
                        state <= FINISH;
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Settings load only in IDLE and a strobe while running is ignored
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mode_q      <= DECOMP_D1;
            num_poly_q  <= '0;
            src_base_q  <= '0;
            dest_base_q <= '0;
        end else if (zeroize_i) begin
            mode_q      <= DECOMP_D1;
            num_poly_q  <= '0;
            src_base_q  <= '0;
            dest_base_q <= '0;
        end else if (state == IDLE && enable_i) begin
            mode_q      <= mode_i;
            num_poly_q  <= num_poly_i;
            src_base_q  <= src_base_i;
            dest_base_q <= dest_base_i;
        end
    end

    assign job.busy      = (state == RUN);
    assign job.mode      = mode_q;
    assign job.num_poly  = num_poly_q;
    assign job.src_base  = src_base_q;
    assign job.dest_base = dest_base_q;

    // One cycle after the last write
    assign done_o = (state == FINISH);

    // Completion only ever comes from the job that is running
    a_write_done_in_run: assert property (@(posedge clk) disable iff (!reset_n)
        write_done_i |-> state == RUN);

endmodule

/* hdl/decompress_job_if.sv */
// Job settings bundle from the control FSM to the counters, gearbox and lanes

`timescale 1ns/1ps

interface decompress_job_if
    import decompress_pkg::*;
#(
    parameter int ADDR_W = 10
) ();

    logic                  busy;
    decompress_mode_t      mode;
    logic [NUM_POLY_W-1:0] num_poly;
    logic [ADDR_W-1:0]     src_base;
    logic [ADDR_W-1:0]     dest_base;

    // Owner of the latched job
    modport fsm_mp (
        output busy,
        output mode,
        output num_poly,
        output src_base,
        output dest_base
    );

    // Datapath side
    modport user_mp (
        input busy,
        input mode,
        input num_poly,
        input src_base,
        input dest_base
    );

endinterface

/* hdl/decompress_pkg.sv */
// Shared ML-KEM decompression types, sizes and the mode-to-width helper for RTL and testbench

package decompress_pkg;

    // Coefficient width d selected per job
    typedef enum logic [1:0] {
        DECOMP_D1  = 2'd0,
        DECOMP_D5  = 2'd1,
        DECOMP_D11 = 2'd2,
        DECOMP_D12 = 2'd3
    } decompress_mode_t;

    localparam int MLKEM_Q       = 3329;
    localparam int Q_WIDTH       = 12;
    localparam int MLKEM_N       = 256;
    localparam int COEFF_PER_CLK = 4;
    localparam int RD_DATA_W     = 64;

    // Four lanes of the widest field
    localparam int GEAR_OUT_W    = COEFF_PER_CLK * Q_WIDTH;

    // Counts 1 to 4 are legal
    localparam int NUM_POLY_W    = 3;

    // Bits per packed coefficient for a mode
    function automatic logic [3:0] decomp_d_width(decompress_mode_t mode);
        logic [3:0] d;
        unique case (mode)
            DECOMP_D1:  d = 4'd1;
            DECOMP_D5:  d = 4'd5;
            DECOMP_D11: d = 4'd11;
            DECOMP_D12: d = 4'd12;
            default:    d = 4'd12;
        endcase
        return d;
    endfunction

endpackage
